/* Makefile */
# Verilator build, run, lint and clean for the datapath testbench

VERILATOR ?= verilator
FILELIST ?= filelist.f
TB_TOP ?= tbDataPath
RTL_TOP ?= dataPath
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing
LINT_FLAGS ?= -Wall
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* alu/adderHold.sv */
// adder hold register
// keeps the ALU result together with its flags for the next cycle,
// so the result can be written while the next op is computed
module adderHold (
  input  logic      phi2,
  input  logic      rstAll,
  input  logic      halt,
  aluFlagsIf.sink   aluRaw,
  aluFlagsIf.source aluHeld
);

  always_ff @(posedge phi2) begin
    if (rstAll) begin
      aluHeld.result <= '0;
      aluHeld.overflow <= 1'b0;
      aluHeld.carry <= 1'b0;
      aluHeld.halfCarry <= 1'b0;
      aluHeld.carryValid <= 1'b0;
      aluHeld.overflowValid <= 1'b0;
    end else if (!halt) begin
      // capture every running cycle, no load enable
      aluHeld.result <= aluRaw.result;
      aluHeld.overflow <= aluRaw.overflow;
      aluHeld.carry <= aluRaw.carry;
      // needed by the decimal adjust stage
      aluHeld.halfCarry <= aluRaw.halfCarry;
      // status reg checks these before taking C and V
      aluHeld.carryValid <= aluRaw.carryValid;
      aluHeld.overflowValid <= aluRaw.overflowValid;
    end
  end

endmodule

/* alu/aluCore.sv */
// ALU core
// combinational add with carry, AND, EOR, OR and shift right,
// with A and B operand selection from the internal buses
module aluCore (
  input  cpuPkg::byteT    sb,
  input  cpuPkg::byteT    db,
  input  logic            aluAFromSb,
  input  cpuPkg::aluBSrcT aluBSrc,
  input  cpuPkg::aluOpT   aluOp,
  input  logic            carryIn,
  aluFlagsIf.source       aluRaw
);
  import cpuPkg::*;

  byteT aOperand;
  byteT bOperand;
  logic [dataWidth:0] fullSum;
  logic [4:0] lowSum;

  // operand select, A is sb or zero
  always_comb begin
    aOperand = aluAFromSb ? sb : '0;
    case (aluBSrc)
      bDb:         bOperand = db;
      // inverted db for subtract
      bDbInverted: bOperand = ~db;
      default:     bOperand = '0;
    endcase
  end

  // binary adder, bit 8 is carry out
  assign fullSum = {1'b0, aOperand} + {1'b0, bOperand} + {{dataWidth{1'b0}}, carryIn};
  // low nibble add for half carry
  assign lowSum = {1'b0, aOperand[3:0]} + {1'b0, bOperand[3:0]} + {4'b0000, carryIn};

  always_comb begin
    // logic ops leave carry and overflow meaningless
    aluRaw.result = '0;
    aluRaw.carry = 1'b0;
    aluRaw.overflow = 1'b0;
    aluRaw.halfCarry = 1'b0;
    aluRaw.carryValid = 1'b0;
    aluRaw.overflowValid = 1'b0;
    case (aluOp)
      aluSum: begin
        aluRaw.result = fullSum[dataWidth-1:0];
        aluRaw.carry = fullSum[dataWidth];
        aluRaw.halfCarry = lowSum[4];
        // same sign in, different sign out
        aluRaw.overflow = (aOperand[7] == bOperand[7]) && (fullSum[7] != aOperand[7]);
        aluRaw.carryValid = 1'b1;
        aluRaw.overflowValid = 1'b1;
      end
      aluAnd: aluRaw.result = aOperand & bOperand;
      aluEor: aluRaw.result = aOperand ^ bOperand;
      aluOr:  aluRaw.result = aOperand | bOperand;
      aluShiftRight: begin
        // carry in rotates into bit 7, bit 0 drops into carry
        aluRaw.result = {carryIn, bOperand[dataWidth-1:1]};
        aluRaw.carry = bOperand[0];
        aluRaw.carryValid = 1'b1;
      end
      default: aluRaw.result = '0;
    endcase
  end

endmodule

/* common/aluFlagsIf.sv */
// ALU result bundle
// carries a result byte with its carry, overflow and half-carry outputs,
// plus the bits saying which of carry and overflow mean anything
interface aluFlagsIf;
  import cpuPkg::*;

  byteT result;
  logic overflow;
  logic carry;
  logic halfCarry;
  // set when the op actually produces a carry / overflow
  logic carryValid;
  logic overflowValid;

  // producer side
  modport source (
    output result, overflow, carry, halfCarry, carryValid, overflowValid
  );

  // consumer side
  modport sink (
    input result, overflow, carry, halfCarry, carryValid, overflowValid
  );

endinterface

/* common/cpuPkg.sv */
// shared definitions for the 6502-style register and ALU datapath
// data width, bus source and ALU operation encodings, status bit
// positions and the decimal adjust constants
package cpuPkg;

  // data word
  localparam int dataWidth = 8;
  typedef logic [dataWidth-1:0] byteT;

  // special bus sources, sbNone reads as zero
  typedef enum logic [2:0] {
    sbNone,
    sbAcc,
    sbX,
    sbY,
    sbS,
    sbAdderHold,
    sbDataLatch
  } sbSrcT;

  // data bus sources, dbNone reads as zero
  typedef enum logic [1:0] {
    dbNone,
    dbAcc,
    dbStatus,
    dbDataLatch
  } dbSrcT;

  // alu operations
  typedef enum logic [2:0] {
    aluSum,
    aluAnd,
    aluEor,
    aluOr,
    aluShiftRight
  } aluOpT;

  // alu B operand select
  typedef enum logic [1:0] {
    bZero,
    bDb,
    bDbInverted
  } aluBSrcT;

  // status register bit positions
  localparam int flagC = 0;
  localparam int flagZ = 1;
  localparam int flagI = 2;
  localparam int flagD = 3;
  localparam int statusOneBit = 5;
  localparam int flagV = 6;
  localparam int flagN = 7;

  // bcd adjust constants
  localparam byteT decimalLowAdjust = 8'h06;
  localparam byteT decimalHighAdjust = 8'h60;
  localparam logic [3:0] decimalNibbleMax = 4'd9;
  localparam byteT decimalByteMax = 8'h99;

endpackage

/* filelist.f */
+incdir+verif
common/cpuPkg.sv
common/aluFlagsIf.sv
alu/aluCore.sv
alu/adderHold.sv
logic/accumulator.sv
logic/indexRegs.sv
logic/statusReg.sv
logic/internalBuses.sv
logic/dataPath.sv
verif/tbDataPath.sv

/* logic/accumulator.sv */
// accumulator
// loads from the special bus through the decimal add/subtract adjust,
// which corrects a binary result into BCD using the held flags
module accumulator (
  input  logic         phi2,
  input  logic         rstAll,
  input  logic         halt,
  input  cpuPkg::byteT sb,
  input  logic         loadAcc,
  input  logic         decimalAdd,
  input  logic         decimalSub,
  aluFlagsIf.sink      aluHeld,
  output cpuPkg::byteT accOut
);
  import cpuPkg::*;

  byteT adjusted;
  byteT accReg;

  // decimal adjust, all steps wrap mod 256
  always_comb begin
    adjusted = sb;
    if (decimalAdd) begin
      // low digit past 9 or carried out of the nibble
      if ((sb[3:0] > decimalNibbleMax) || aluHeld.halfCarry) begin
        adjusted = adjusted + decimalLowAdjust;
      end
      // high digit check looks at the unadjusted byte
      if (aluHeld.carry || (sb > decimalByteMax)) begin
        adjusted = adjusted + decimalHighAdjust;
      end
    end else if (decimalSub) begin
      // no half carry means a borrow from the low digit
      if (!aluHeld.halfCarry) begin
        adjusted = adjusted - decimalLowAdjust;
      end
      // likewise for the high digit
      if (!aluHeld.carry) begin
        adjusted = adjusted - decimalHighAdjust;
      end
    end
  end

  always_ff @(posedge phi2) begin
    if (rstAll) begin
      accReg <= '0;
    end else if (!halt && loadAcc) begin
      accReg <= adjusted;
    end
  end

  assign accOut = accReg;

endmodule

/* logic/dataPath.sv */
// datapath top level
// register and ALU half of a 6502-style CPU, driven by one control
// word per phi2 cycle from an external sequencer
module dataPath (
  input  logic            phi2,
  input  logic            rstAll,
  input  logic            halt,
  input  cpuPkg::byteT    dataIn,
  input  cpuPkg::sbSrcT   sbSrc,
  input  cpuPkg::dbSrcT   dbSrc,
  input  logic            aluAFromSb,
  input  cpuPkg::aluBSrcT aluBSrc,
  input  cpuPkg::aluOpT   aluOp,
  input  logic            carryIn,
  input  logic            decimalAdd,
  input  logic            decimalSub,
  input  logic            loadAcc,
  input  logic            loadX,
  input  logic            loadY,
  input  logic            loadS,
  input  logic            flagsFromAlu,
  input  logic            flagsFromDb,
  input  logic            dbToStatus,
  input  logic            setCarry,
  input  logic            clrCarry,
  input  logic            setInt,
  input  logic            clrInt,
  input  logic            setDec,
  input  logic            clrDec,
  input  logic            clrOverflow,
  output cpuPkg::byteT    accOut,
  output cpuPkg::byteT    xOut,
  output cpuPkg::byteT    yOut,
  output cpuPkg::byteT    sOut,
  output cpuPkg::byteT    statusOut
);
  import cpuPkg::*;

  byteT sb;
  byteT db;

  // alu output before and after the hold register
  aluFlagsIf aluRaw ();
  aluFlagsIf aluHeld ();

  internalBuses iInternalBuses (
    .phi2(phi2), .rstAll(rstAll), .halt(halt), .dataIn(dataIn),
    .sbSrc(sbSrc), .dbSrc(dbSrc), .accOut(accOut), .xOut(xOut), .yOut(yOut),
    .sOut(sOut), .statusOut(statusOut), .heldResult(aluHeld.result),
    .sb(sb), .db(db)
  );

  aluCore iAluCore (
    .sb(sb), .db(db), .aluAFromSb(aluAFromSb), .aluBSrc(aluBSrc),
    .aluOp(aluOp), .carryIn(carryIn), .aluRaw(aluRaw)
  );

  // one cycle between alu and any register write
  adderHold iAdderHold (
    .phi2(phi2), .rstAll(rstAll), .halt(halt), .aluRaw(aluRaw), .aluHeld(aluHeld)
  );

  accumulator iAccumulator (
    .phi2(phi2), .rstAll(rstAll), .halt(halt), .sb(sb), .loadAcc(loadAcc),
    .decimalAdd(decimalAdd), .decimalSub(decimalSub), .aluHeld(aluHeld),
    .accOut(accOut)
  );

  indexRegs iIndexRegs (
    .phi2(phi2), .rstAll(rstAll), .halt(halt), .sb(sb), .loadX(loadX),
    .loadY(loadY), .loadS(loadS), .xOut(xOut), .yOut(yOut), .sOut(sOut)
  );

  statusReg iStatusReg (
    .phi2(phi2), .rstAll(rstAll), .halt(halt), .db(db), .aluHeld(aluHeld),
    .flagsFromAlu(flagsFromAlu), .flagsFromDb(flagsFromDb),
    .dbToStatus(dbToStatus), .setCarry(setCarry), .clrCarry(clrCarry),
    .setInt(setInt), .clrInt(clrInt), .setDec(setDec), .clrDec(clrDec),
    .clrOverflow(clrOverflow), .statusOut(statusOut)
  );

endmodule

/* logic/indexRegs.sv */
// index and stack registers
// X, Y and the stack pointer S, all loaded from the special bus;
// any combination may load on the same edge
module indexRegs (
  input  logic         phi2,
  input  logic         rstAll,
  input  logic         halt,
  input  cpuPkg::byteT sb,
  input  logic         loadX,
  input  logic         loadY,
  input  logic         loadS,
  output cpuPkg::byteT xOut,
  output cpuPkg::byteT yOut,
  output cpuPkg::byteT sOut
);
  import cpuPkg::*;

  // entry 0 is X, 1 is Y, 2 is S
  byteT regBank [3];
  logic [2:0] loadVec;

  assign loadVec = {loadS, loadY, loadX};

  always_ff @(posedge phi2) begin
    if (rstAll) begin
      for (int i = 0; i < 3; i++) begin
        regBank[i] <= '0;
      end
    end else if (!halt) begin
      // sb is the only input, each reg has its own enable
      for (int i = 0; i < 3; i++) begin
        if (loadVec[i]) begin
          regBank[i] <= sb;
        end
      end
    end
  end

  assign xOut = regBank[0];
  assign yOut = regBank[1];
  assign sOut = regBank[2];

endmodule

/* logic/internalBuses.sv */
// internal buses
// input data latch plus the special bus and data bus, built as
// source multiplexers; an unselected bus reads as zero
module internalBuses (
  input  logic          phi2,
  input  logic          rstAll,
  input  logic          halt,
  input  cpuPkg::byteT  dataIn,
  input  cpuPkg::sbSrcT sbSrc,
  input  cpuPkg::dbSrcT dbSrc,
  input  cpuPkg::byteT  accOut,
  input  cpuPkg::byteT  xOut,
  input  cpuPkg::byteT  yOut,
  input  cpuPkg::byteT  sOut,
  input  cpuPkg::byteT  statusOut,
  input  cpuPkg::byteT  heldResult,
  output cpuPkg::byteT  sb,
  output cpuPkg::byteT  db
);
  import cpuPkg::*;

  byteT dataLatch;

  // external bus captured every running cycle
  always_ff @(posedge phi2) begin
    if (rstAll) begin
      dataLatch <= '0;
    end else if (!halt) begin
      dataLatch <= dataIn;
    end
  end

  // special bus mux
  always_comb begin
    case (sbSrc)
      sbAcc:       sb = accOut;
      sbX:         sb = xOut;
      sbY:         sb = yOut;
      sbS:         sb = sOut;
      sbAdderHold: sb = heldResult;
      sbDataLatch: sb = dataLatch;
      default:     sb = '0;
    endcase
  end

  // data bus mux
  always_comb begin
    case (dbSrc)
      dbAcc:       db = accOut;
      dbStatus:    db = statusOut;
      dbDataLatch: db = dataLatch;
      default:     db = '0;
    endcase
  end

endmodule

/* logic/statusReg.sv */
// processor status register
// N, V, D, I, Z and C with updates from the held ALU result,
// from the data bus and from the sequencer's set/clear controls
module statusReg (
  input  logic         phi2,
  input  logic         rstAll,
  input  logic         halt,
  input  cpuPkg::byteT db,
  aluFlagsIf.sink      aluHeld,
  input  logic         flagsFromAlu,
  input  logic         flagsFromDb,
  input  logic         dbToStatus,
  input  logic         setCarry,
  input  logic         clrCarry,
  input  logic         setInt,
  input  logic         clrInt,
  input  logic         setDec,
  input  logic         clrDec,
  input  logic         clrOverflow,
  output cpuPkg::byteT statusOut
);
  import cpuPkg::*;

  logic nFlag, vFlag, dFlag, iFlag, zFlag, cFlag;

  always_ff @(posedge phi2) begin
    if (rstAll) begin
      nFlag <= 1'b0;
      vFlag <= 1'b0;
      dFlag <= 1'b0;
      iFlag <= 1'b0;
      zFlag <= 1'b0;
      cFlag <= 1'b0;
    end else if (!halt) begin
      // N, sign of alu result or of db
      if (flagsFromAlu) nFlag <= aluHeld.result[7];
      else if (flagsFromDb || dbToStatus) nFlag <= db[flagN];

      // Z, zero test unless restoring the whole byte
      if (flagsFromAlu) zFlag <= (aluHeld.result == '0);
      else if (flagsFromDb) zFlag <= (db == '0);
      else if (dbToStatus) zFlag <= db[flagZ];

      // C, only when the op produced a real carry
      if (flagsFromAlu && aluHeld.carryValid) cFlag <= aluHeld.carry;
      else if (dbToStatus) cFlag <= db[flagC];
      else if (setCarry) cFlag <= 1'b1;
      else if (clrCarry) cFlag <= 1'b0;

      // V, only after a sum
      if (flagsFromAlu && aluHeld.overflowValid) vFlag <= aluHeld.overflow;
      else if (dbToStatus) vFlag <= db[flagV];
      else if (clrOverflow) vFlag <= 1'b0;

      // D and I, restore first, then set, then clear
      if (dbToStatus) dFlag <= db[flagD];
      else if (setDec) dFlag <= 1'b1;
      else if (clrDec) dFlag <= 1'b0;

      if (dbToStatus) iFlag <= db[flagI];
      else if (setInt) iFlag <= 1'b1;
      else if (clrInt) iFlag <= 1'b0;
    end
  end

  // assemble the byte, bit 4 reads 0 and bit 5 reads 1
  always_comb begin
    statusOut = '0;
    statusOut[flagN] = nFlag;
    statusOut[flagV] = vFlag;
    statusOut[statusOneBit] = 1'b1;
    statusOut[flagD] = dFlag;
    statusOut[flagI] = iFlag;
    statusOut[flagZ] = zFlag;
    statusOut[flagC] = cFlag;
  end

endmodule

/* verif/dataPathTests.svh */
// directed datapath tests
// bus helpers, reference rules for binary add and decimal adjust,
// and one task per test; included inside the testbench top

// byte sits in the data latch after this cycle
task automatic latchData(input byteT value);
  dataIn = value;
  tick();
endtask

task automatic putInAcc(input byteT value);
  latchData(value);
  sbSrc = sbDataLatch;
  loadAcc = 1'b1;
  tick();
endtask

// acc op latched byte into the hold register
task automatic computeOnAcc(input byteT a, input byteT b, input aluOpT op,
                            input aluBSrcT bSrc, input logic cin);
  putInAcc(a);
  latchData(b);
  sbSrc = sbAcc;
  aluAFromSb = 1'b1;
  dbSrc = dbDataLatch;
  aluBSrc = bSrc;
  aluOp = op;
  carryIn = cin;
  tick();
endtask

// held result back into acc with optional flags or bcd adjust
task automatic writeHeldToAcc(input logic withFlags, input logic decAdd, input logic decSub);
  sbSrc = sbAdderHold;
  loadAcc = 1'b1;
  flagsFromAlu = withFlags;
  decimalAdd = decAdd;
  decimalSub = decSub;
  tick();
endtask

// packed as overflow, halfCarry, carry, sum
function automatic logic [10:0] addRef(input byteT a, input byteT b, input logic cin);
  int total;
  int signedTotal;
  logic half;
  total = int'(a) + int'(b) + int'(cin);
  // overflow means the signed sum leaves -128..127
  signedTotal = int'($signed(a)) + int'($signed(b)) + int'(cin);
  half = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
  return {(signedTotal > 127) || (signedTotal < -128), half, total > 255, byteT'(total)};
endfunction

function automatic byteT adjustRef(input byteT bin, input logic half, input logic carry,
                                   input logic isAdd);
  int value;
  value = int'(bin);
  if (isAdd) begin
    if ((bin[3:0] > 4'd9) || half) value += 6;
    // high step tests the unadjusted byte
    if (carry || (bin > 8'h99)) value += 'h60;
  end else begin
    if (!half) value -= 6;
    if (!carry) value -= 'h60;
  end
  // wraps mod 256
  return byteT'(value);
endfunction

function automatic byteT nzApplied(input byteT status, input byteT res);
  byteT updated;
  updated = status;
  updated[flagN] = res[7];
  updated[flagZ] = (res == 8'h00);
  return updated;
endfunction

task automatic checkReset();
  expectByte("A after reset", accOut, 8'h00);
  expectByte("X after reset", xOut, 8'h00);
  expectByte("Y after reset", yOut, 8'h00);
  expectByte("S after reset", sOut, 8'h00);
  // only the always-one bit
  expectByte("status after reset", statusOut, 8'h20);
  finishTest("reset");
endtask

task automatic loadsAndHalt();
  byteT vals [4];
  for (int i = 0; i < 4; i++) begin
    vals[i] = byteT'($urandom());
    latchData(vals[i]);
    sbSrc = sbDataLatch;
    loadAcc = (i == 0);
    loadX = (i == 1);
    loadY = (i == 2);
    loadS = (i == 3);
    tick();
  end
  expectByte("A load", accOut, vals[0]);
  expectByte("X load", xOut, vals[1]);
  expectByte("Y load", yOut, vals[2]);
  expectByte("S load", sOut, vals[3]);
  // every load and some flag sets requested while halted
  repeat (5) begin
    halt = 1'b1;
    dataIn = byteT'($urandom());
    sbSrc = sbDataLatch;
    loadAcc = 1'b1;
    loadX = 1'b1;
    loadY = 1'b1;
    loadS = 1'b1;
    setCarry = 1'b1;
    setDec = 1'b1;
    tick();
    expectByte("A in halt", accOut, vals[0]);
    expectByte("X in halt", xOut, vals[1]);
    expectByte("Y in halt", yOut, vals[2]);
    expectByte("S in halt", sOut, vals[3]);
    expectByte("status in halt", statusOut, statusModel);
  end
  finishTest("loads and halt");
endtask

task automatic binaryAdd();
  byteT a;
  byteT b;
  logic cin;
  logic sub;
  logic [10:0] expected;
  repeat (8) begin
    a = byteT'($urandom());
    b = byteT'($urandom());
    cin = 1'($urandom());
    sub = 1'($urandom());
    computeOnAcc(a, b, aluSum, sub ? bDbInverted : bDb, cin);
    writeHeldToAcc(1'b1, 1'b0, 1'b0);
    expected = addRef(a, sub ? ~b : b, cin);
    statusModel = nzApplied(statusModel, expected[7:0]);
    statusModel[flagC] = expected[8];
    statusModel[flagV] = expected[10];
    expectByte("sum", accOut, expected[7:0]);
    expectByte("status after sum", statusOut, statusModel);
  end
  finishTest("binary add");
endtask

task automatic logicAndShift();
  byteT a;
  byteT b;
  byteT res;
  logic cin;
  logic preset;
  aluOpT op;
  // 40 plus 40 overflows into 80, so V is set for the ops to keep
  computeOnAcc(8'h40, 8'h40, aluSum, bDb, 1'b0);
  writeHeldToAcc(1'b1, 1'b0, 1'b0);
  statusModel = nzApplied(statusModel, 8'h80);
  statusModel[flagC] = 1'b0;
  statusModel[flagV] = 1'b1;
  expectByte("status after overflow preset", statusOut, statusModel);
  for (int i = 0; i < 8; i++) begin
    a = byteT'($urandom());
    b = byteT'($urandom());
    cin = 1'($urandom());
    // known carry going in
    preset = 1'($urandom());
    setCarry = preset;
    clrCarry = !preset;
    tick();
    statusModel[flagC] = preset;
    case (i % 4)
      0: op = aluAnd;
      1: op = aluEor;
      2: op = aluOr;
      default: op = aluShiftRight;
    endcase
    case (op)
      aluAnd: res = a & b;
      aluEor: res = a ^ b;
      aluOr: res = a | b;
      // carry in enters at the top
      default: res = {cin, b[7:1]};
    endcase
    computeOnAcc(a, b, op, bDb, cin);
    writeHeldToAcc(1'b1, 1'b0, 1'b0);
    statusModel = nzApplied(statusModel, res);
    if (op == aluShiftRight) statusModel[flagC] = b[0];
    expectByte("logic or shift result", accOut, res);
    expectByte("status after logic or shift", statusOut, statusModel);
  end
  finishTest("logic and shift");
endtask

task automatic bcdAddSub();
  byteT a;
  byteT b;
  logic isAdd;
  logic cin;
  logic [10:0] raw;
  for (int i = 0; i < 6; i++) begin
    a = {4'($urandom_range(9, 0)), 4'($urandom_range(9, 0))};
    b = {4'($urandom_range(9, 0)), 4'($urandom_range(9, 0))};
    isAdd = (i % 2 == 0);
    // subtract runs with carry in set as no borrow
    cin = isAdd ? 1'($urandom()) : 1'b1;
    computeOnAcc(a, b, aluSum, isAdd ? bDb : bDbInverted, cin);
    writeHeldToAcc(1'b0, isAdd, !isAdd);
    raw = addRef(a, isAdd ? b : ~b, cin);
    expectByte("decimal result", accOut, adjustRef(raw[7:0], raw[9], raw[8], isAdd));
    expectByte("status after decimal op", statusOut, statusModel);
  end
  finishTest("decimal adjust");
endtask

task automatic statusPaths();
  int flagOf [6];
  byteT value;
  flagOf = '{flagC, flagC, flagI, flagI, flagD, flagD};
  for (int k = 0; k < 6; k++) begin
    setCarry = (k == 0);
    clrCarry = (k == 1);
    setInt = (k == 2);
    clrInt = (k == 3);
    setDec = (k == 4);
    clrDec = (k == 5);
    tick();
    // even steps set and odd steps clear
    statusModel[flagOf[k]] = (k % 2 == 0);
    expectByte("status after set or clear", statusOut, statusModel);
  end
  // whole byte restore with V forced on so the clear shows
  value = byteT'($urandom()) | 8'h40;
  latchData(value);
  dbSrc = dbDataLatch;
  dbToStatus = 1'b1;
  tick();
  statusModel = (value & 8'hEF) | 8'h20;
  expectByte("status restored from db", statusOut, statusModel);
  clrOverflow = 1'b1;
  tick();
  statusModel[flagV] = 1'b0;
  expectByte("status after clrOverflow", statusOut, statusModel);
  // zero byte and then a negative one
  latchData(8'h00);
  dbSrc = dbDataLatch;
  flagsFromDb = 1'b1;
  tick();
  statusModel = nzApplied(statusModel, 8'h00);
  expectByte("status after zero db", statusOut, statusModel);
  value = byteT'($urandom()) | 8'h80;
  latchData(value);
  dbSrc = dbDataLatch;
  flagsFromDb = 1'b1;
  tick();
  statusModel = nzApplied(statusModel, value);
  expectByte("status after negative db", statusOut, statusModel);
  finishTest("status paths");
endtask

/* verif/tbDataPath.sv */
// datapath testbench top
// clock, reset, DUT, run limit and the check counters; the directed
// tests and their reference rules come from the included test file
module tbDataPath;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  // tests plus reset take about 170 cycles
  localparam int cycleLimit = 400;

  logic phi2;
  logic rstAll;
  logic halt;
  byteT dataIn;
  sbSrcT sbSrc;
  dbSrcT dbSrc;
  logic aluAFromSb;
  aluBSrcT aluBSrc;
  aluOpT aluOp;
  logic carryIn;
  logic decimalAdd;
  logic decimalSub;
  logic loadAcc;
  logic loadX;
  logic loadY;
  logic loadS;
  logic flagsFromAlu;
  logic flagsFromDb;
  logic dbToStatus;
  logic setCarry;
  logic clrCarry;
  logic setInt;
  logic clrInt;
  logic setDec;
  logic clrDec;
  logic clrOverflow;
  byteT accOut;
  byteT xOut;
  byteT yOut;
  byteT sOut;
  byteT statusOut;

  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int testStartErrors = 0;
  // expected status byte carried across tests
  byteT statusModel;

  dataPath i_dataPath (.*);

  initial phi2 = 1'b0;
  always #5 phi2 = ~phi2;

  // run limit
  always @(posedge phi2) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: tests still running after %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // no-op control word
  task automatic idleControls();
    halt = 1'b0;
    sbSrc = sbNone;
    dbSrc = dbNone;
    aluAFromSb = 1'b0;
    aluBSrc = bZero;
    aluOp = aluSum;
    carryIn = 1'b0;
    decimalAdd = 1'b0;
    decimalSub = 1'b0;
    loadAcc = 1'b0;
    loadX = 1'b0;
    loadY = 1'b0;
    loadS = 1'b0;
    flagsFromAlu = 1'b0;
    flagsFromDb = 1'b0;
    dbToStatus = 1'b0;
    setCarry = 1'b0;
    clrCarry = 1'b0;
    setInt = 1'b0;
    clrInt = 1'b0;
    setDec = 1'b0;
    clrDec = 1'b0;
    clrOverflow = 1'b0;
  endtask

  // one full cycle ending on the falling edge with controls idle
  task automatic tick();
    @(negedge phi2);
    idleControls();
  endtask

  task automatic expectByte(input string what, input byteT got, input byteT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic finishTest(input string name);
    if (errorCount == testStartErrors) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail, %0d errors", name, errorCount - testStartErrors);
    end
    testStartErrors = errorCount;
  endtask

  `include "dataPathTests.svh"

  initial begin
    void'($urandom(71455));
    rstAll = 1'b1;
    dataIn = '0;
    idleControls();
    statusModel = 8'h20;
    repeat (16) @(posedge phi2);
    @(negedge phi2);
    rstAll = 1'b0;
    checkReset();
    loadsAndHalt();
    binaryAdd();
    logicAndShift();
    bcdAddSub();
    statusPaths();
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
